// ==== common/ime_config.svh ====
`ifndef IME_CONFIG_SVH
`define IME_CONFIG_SVH

// ------------------------------------------------------------
// pixel and block geometry
// ------------------------------------------------------------
`define IME_BIT_DEPTH   8
`define IME_MB_W        16
// candidate columns per array position, also pixels per right step
`define IME_PE_NUM      4

// ------------------------------------------------------------
// search window and scan
// ------------------------------------------------------------
`define IME_SW_W        48
`define IME_SW_H        48
`define IME_COL_STEPS   8
// vertical positions per column
`define IME_ROW_POS     33

// ------------------------------------------------------------
// motion vector, qp and lambda widths
// ------------------------------------------------------------
`define IME_MV_OFS      16
`define IME_MV_W        6
`define IME_QP_W        6
`define IME_LAMBDA_W    9

`endif

// ==== common/ime_pkg.sv ====
`include "ime_config.svh"

package ime_pkg;

    // derived widths
    localparam int ARR_W = `IME_MB_W + 2 * `IME_PE_NUM - 1;
    localparam int REF_W = `IME_MB_W + `IME_PE_NUM - 1;
    // window row plus zero padding for the last column offset
    localparam int EXT_W = `IME_SW_W + `IME_PE_NUM - 1;
    localparam int COL_W = $clog2(`IME_COL_STEPS);
    localparam int ROW_W = $clog2(`IME_SW_H);
    localparam int MV_W  = `IME_MV_W;

    typedef logic [`IME_BIT_DEPTH-1:0] pixel_t;

    // index j is window column j
    typedef pixel_t [`IME_SW_W-1:0] sw_row_t;
    typedef pixel_t [EXT_W-1:0]     ext_row_t;
    typedef pixel_t [ARR_W-1:0]     arr_row_t;
    typedef pixel_t [REF_W-1:0]     ref_row_t;
    // index k is block row k, row 0 at the top
    typedef ref_row_t [`IME_MB_W-1:0] ref_blk_t;

    typedef logic [`IME_QP_W-1:0]     qp_t;
    typedef logic [`IME_LAMBDA_W-1:0] lambda_t;

    typedef struct packed {
        logic signed [MV_W-1:0] mv_x;
        logic signed [MV_W-1:0] mv_y;
    } ime_mv_t;

    typedef struct packed {
        logic             load;
        logic [ROW_W-1:0] addr;
    } fetch_req_t;

    typedef enum logic [1:0] {
        ARR_HOLD,
        ARR_SHIFT_DN,
        ARR_SHIFT_UP,
        ARR_SHIFT_RT
    } array_op_e;

    // position held by the array once the current operation is done
    typedef struct packed {
        logic [COL_W-1:0] col;
        logic [ROW_W-1:0] row;
        logic             valid;
    } scan_pos_t;

endpackage

// ==== ref_array/ref_row_array.sv ====
`include "ime_config.svh"

module ref_row_array
    import ime_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    input  array_op_e        array_op_i,
    input  logic [COL_W-1:0] col_shift_i,
    input  sw_row_t          fetch_data_i,
    output ref_blk_t         ref_blk_o
);

    localparam int PAD_W = (EXT_W - `IME_SW_W) * `IME_BIT_DEPTH;

    ext_row_t fetch_ext;
    arr_row_t fetch_slice;
    arr_row_t rows_q [`IME_MB_W];

    // ------------------------------------------------------------
    // column offset selection
    // ------------------------------------------------------------
    // zeros beyond the right window edge
    assign fetch_ext   = {{PAD_W{1'b0}}, fetch_data_i};
    assign fetch_slice = fetch_ext[col_shift_i * `IME_PE_NUM +: ARR_W];

    // ------------------------------------------------------------
    // row array
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        case (array_op_i)
            ARR_SHIFT_DN: begin
                // window moves down, new row enters at the bottom
                for (int k = 0; k < `IME_MB_W - 1; k++) begin
                    rows_q[k] <= rows_q[k+1];
                end
                rows_q[`IME_MB_W-1] <= fetch_slice;
            end
            ARR_SHIFT_UP: begin
                for (int k = 1; k < `IME_MB_W; k++) begin
                    rows_q[k] <= rows_q[k-1];
                end
                rows_q[0] <= fetch_slice;
            end
            ARR_SHIFT_RT: begin
                // drop the leftmost pixels, zero fill on the right
                for (int k = 0; k < `IME_MB_W; k++) begin
                    rows_q[k] <= {{(`IME_PE_NUM * `IME_BIT_DEPTH){1'b0}},
                                  rows_q[k][ARR_W-1:`IME_PE_NUM]};
                end
            end
            default: begin
            end
        endcase
    end

    // candidate block is the left part of each row
    always_comb begin
        for (int k = 0; k < `IME_MB_W; k++) begin
            ref_blk_o[k] = rows_q[k][REF_W-1:0];
        end
    end

    a_op_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(array_op_i));

endmodule

// ==== hw/lambda_lut.sv ====
`include "ime_config.svh"

module lambda_lut
    import ime_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  qp_t     qp_i,
    input  logic    capture_i,
    output lambda_t lambda_o
);

    localparam int QP_NUM = 1 << `IME_QP_W;

    // x264 lambda per qp, eight entries per line
    localparam lambda_t LAMBDA_TAB [QP_NUM] = '{
          1,   1,   1,   1,   1,   1,   1,   1,
          1,   1,   1,   1,   1,   1,   1,   1,
          2,   2,   2,   2,   3,   3,   3,   4,
          4,   4,   5,   6,   6,   7,   8,   9,
         10,  11,  13,  14,  16,  18,  20,  23,
         25,  29,  32,  36,  40,  45,  51,  57,
         64,  72,  81,  91, 102, 114, 128, 144,
        161, 181, 203, 228, 256, 287, 323, 362
    };

    // held until the next frame captures a new qp
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lambda_o <= '0;
        end else if (capture_i) begin
            lambda_o <= LAMBDA_TAB[qp_i];
        end
    end

endmodule

// ==== hw/mv_align.sv ====
`include "ime_config.svh"

module mv_align
    import ime_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  scan_pos_t scan_pos_i,
    output logic      run_o,
    output ime_mv_t   mv_o,
    output logic      done_o
);

    // d1 lines up with the array op, d2 with the array contents
    scan_pos_t pos_d1;
    scan_pos_t pos_d2;
    logic      done_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pos_d1 <= '0;
            pos_d2 <= '0;
            done_q <= 1'b0;
        end else begin
            pos_d1 <= scan_pos_i;
            pos_d2 <= pos_d1;
            // falling edge of the aligned valid
            done_q <= pos_d2.valid && !pos_d1.valid;
        end
    end

    assign run_o  = pos_d2.valid;
    assign done_o = done_q;

    // window offset removed, two's complement wrap gives the sign
    always_comb begin
        mv_o.mv_x = MV_W'(pos_d2.col) * MV_W'(`IME_PE_NUM) - MV_W'(`IME_MV_OFS);
        mv_o.mv_y = MV_W'(pos_d2.row) - MV_W'(`IME_MV_OFS);
    end

    a_mv_y_range: assert property (@(posedge clk) disable iff (!rstn)
        run_o |-> (mv_o.mv_y >= -MV_W'(`IME_MV_OFS)) && (mv_o.mv_y <= MV_W'(`IME_MV_OFS)));

endmodule

// ==== hw/ime_scan_ctrl.sv ====
`include "ime_config.svh"

module ime_scan_ctrl
    import ime_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    input  logic             start_i,
    input  logic             fetch_valid_i,
    output logic             fetch_start_o,
    output fetch_req_t       fetch_req_o,
    output array_op_e        array_op_o,
    output logic [COL_W-1:0] col_shift_o,
    output logic             lambda_capture_o,
    output scan_pos_t        scan_pos_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_WIN,
        LOAD,
        SCAN_DN,
        STEP_RT,
        SCAN_UP
    } ctrl_state_e;

    localparam logic [COL_W-1:0] LAST_COL = COL_W'(`IME_COL_STEPS - 1);

    ctrl_state_e      state_q, state_d;
    logic [ROW_W-1:0] row_q, row_d;
    logic [COL_W-1:0] col_q, col_d;
    logic [1:0]       tail_q;
    logic             start_ok;
    logic             scan_last;
    array_op_e        op_d;

    // new frames wait until the output pipeline has drained
    assign start_ok         = (state_q == IDLE) && start_i && (tail_q == 2'd0);
    assign lambda_capture_o = start_ok;

    // ------------------------------------------------------------
    // snake scan sequencing
    // ------------------------------------------------------------
    always_comb begin
        state_d     = state_q;
        row_d       = row_q;
        col_d       = col_q;
        op_d        = ARR_HOLD;
        fetch_req_o = '0;
        scan_pos_o  = '0;
        scan_last   = 1'b0;
        case (state_q)
            IDLE: begin
                if (start_ok) begin
                    state_d = WAIT_WIN;
                    row_d   = '0;
                    col_d   = '0;
                end
            end
            WAIT_WIN: begin
                if (fetch_valid_i) begin
                    state_d = LOAD;
                end
            end
            LOAD: begin
                fetch_req_o.load = 1'b1;
                fetch_req_o.addr = row_q;
                op_d             = ARR_SHIFT_DN;
                row_d            = row_q + 1'b1;
                // last load row completes the first candidate
                if (row_q == ROW_W'(`IME_MB_W - 1)) begin
                    scan_pos_o.valid = 1'b1;
                    scan_pos_o.col   = col_q;
                    scan_pos_o.row   = '0;
                    row_d            = '0;
                    state_d          = SCAN_DN;
                end
            end
            SCAN_DN: begin
                fetch_req_o.load = 1'b1;
                fetch_req_o.addr = row_q + ROW_W'(`IME_MB_W);
                op_d             = ARR_SHIFT_DN;
                row_d            = row_q + 1'b1;
                scan_pos_o.valid = 1'b1;
                scan_pos_o.col   = col_q;
                scan_pos_o.row   = row_d;
                if (row_q == ROW_W'(`IME_ROW_POS - 2)) begin
                    state_d = STEP_RT;
                end
            end
            STEP_RT: begin
                // no fetch, the step is itself a candidate
                op_d             = ARR_SHIFT_RT;
                col_d            = col_q + 1'b1;
                scan_pos_o.valid = 1'b1;
                scan_pos_o.col   = col_d;
                scan_pos_o.row   = row_q;
                state_d          = (row_q == '0) ? SCAN_DN : SCAN_UP;
            end
            SCAN_UP: begin
                fetch_req_o.load = 1'b1;
                fetch_req_o.addr = row_q - 1'b1;
                op_d             = ARR_SHIFT_UP;
                row_d            = row_q - 1'b1;
                scan_pos_o.valid = 1'b1;
                scan_pos_o.col   = col_q;
                scan_pos_o.row   = row_d;
                if (row_q == ROW_W'(1)) begin
                    scan_last = (col_q == LAST_COL);
                    state_d   = scan_last ? IDLE : STEP_RT;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q       <= IDLE;
            row_q         <= '0;
            col_q         <= '0;
            tail_q        <= 2'd0;
            fetch_start_o <= 1'b0;
            array_op_o    <= ARR_HOLD;
            col_shift_o   <= '0;
        end else begin
            state_q       <= state_d;
            row_q         <= row_d;
            col_q         <= col_d;
            fetch_start_o <= start_ok;
            // fetched data returns one cycle later, together with its op
            array_op_o    <= op_d;
            col_shift_o   <= col_q;
            if (scan_last) begin
                tail_q <= 2'd3;
            end else if (tail_q != 2'd0) begin
                tail_q <= tail_q - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    a_addr_in_window: assert property (@(posedge clk) disable iff (!rstn)
        fetch_req_o.load |-> (fetch_req_o.addr < ROW_W'(`IME_SW_H)));

    a_step_not_last_col: assert property (@(posedge clk) disable iff (!rstn)
        (state_q == STEP_RT) |-> (col_q != LAST_COL));

endmodule

// ==== hw/ime_top.sv ====
module ime_top
    import ime_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,

    // system side
    input  logic       start_i,
    input  qp_t        qp_i,
    output logic       done_o,

    // fetch side
    output logic       fetch_start_o,
    input  logic       fetch_valid_i,
    output fetch_req_t fetch_req_o,
    input  sw_row_t    fetch_data_i,

    // sad tree side
    output logic       sad_run_o,
    output ime_mv_t    sad_mv_o,
    output lambda_t    sad_lambda_o,
    output ref_blk_t   sad_ref_blk_o
);

    array_op_e        array_op;
    logic [COL_W-1:0] col_shift;
    logic             lambda_capture;
    scan_pos_t        scan_pos;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    ime_scan_ctrl i_ime_scan_ctrl (
        .clk              (clk),
        .rstn             (rstn),
        .start_i          (start_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_start_o    (fetch_start_o),
        .fetch_req_o      (fetch_req_o),
        .array_op_o       (array_op),
        .col_shift_o      (col_shift),
        .lambda_capture_o (lambda_capture),
        .scan_pos_o       (scan_pos)
    );

    lambda_lut i_lambda_lut (
        .clk       (clk),
        .rstn      (rstn),
        .qp_i      (qp_i),
        .capture_i (lambda_capture),
        .lambda_o  (sad_lambda_o)
    );

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    ref_row_array i_ref_row_array (
        .clk          (clk),
        .rstn         (rstn),
        .array_op_i   (array_op),
        .col_shift_i  (col_shift),
        .fetch_data_i (fetch_data_i),
        .ref_blk_o    (sad_ref_blk_o)
    );

    mv_align i_mv_align (
        .clk        (clk),
        .rstn       (rstn),
        .scan_pos_i (scan_pos),
        .run_o      (sad_run_o),
        .mv_o       (sad_mv_o),
        .done_o     (done_o)
    );

endmodule

// ==== dv/tb_ime_top.sv ====
`include "ime_config.svh"

module tb_ime_top
    import ime_pkg::*;
();

    localparam int SCAN_CANDS   = `IME_COL_STEPS * `IME_ROW_POS;
    localparam int REQ_CYCLES   = `IME_MB_W + SCAN_CANDS - 1;
    localparam int FRAMES       = 5;
    localparam int FRAME_CYCLES = 400;
    // two extra frame budgets cover reset and the lambda checks
    localparam int WATCHDOG_CYCLES = (FRAMES + 2) * FRAME_CYCLES;

    logic       clk;
    logic       rstn;
    logic       start_i;
    qp_t        qp_i;
    logic       done_o;
    logic       fetch_start_o;
    logic       fetch_valid_i;
    fetch_req_t fetch_req_o;
    sw_row_t    fetch_data_i;
    logic       sad_run_o;
    ime_mv_t    sad_mv_o;
    lambda_t    sad_lambda_o;
    ref_blk_t   sad_ref_blk_o;

    int         errors;
    integer     seed;
    logic [7:0] base;
    fetch_req_t model_req;

    ime_top i_ime_top (
        .clk           (clk),
        .rstn          (rstn),
        .start_i       (start_i),
        .qp_i          (qp_i),
        .done_o        (done_o),
        .fetch_start_o (fetch_start_o),
        .fetch_valid_i (fetch_valid_i),
        .fetch_req_o   (fetch_req_o),
        .fetch_data_i  (fetch_data_i),
        .sad_run_o     (sad_run_o),
        .sad_mv_o      (sad_mv_o),
        .sad_lambda_o  (sad_lambda_o),
        .sad_ref_blk_o (sad_ref_blk_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ------------------------------------------------------------
    // window model and expected values
    // ------------------------------------------------------------
    function automatic pixel_t window_pix(input int r, input int c);
        if (c >= `IME_SW_W) begin
            return '0;
        end
        return pixel_t'(int'(base) + 5 * r + 3 * c);
    endfunction

    function automatic sw_row_t window_row(input int r);
        sw_row_t row;
        for (int j = 0; j < `IME_SW_W; j++) begin
            row[j] = window_pix(r, j);
        end
        return row;
    endfunction

    function automatic lambda_t expect_lambda(input qp_t qp);
        lambda_t tab [48];
        tab = '{  2,   2,   2,   2,   3,   3,   3,   4,
                  4,   4,   5,   6,   6,   7,   8,   9,
                 10,  11,  13,  14,  16,  18,  20,  23,
                 25,  29,  32,  36,  40,  45,  51,  57,
                 64,  72,  81,  91, 102, 114, 128, 144,
                161, 181, 203, 228, 256, 287, 323, 362};
        if (qp < 16) begin
            return 1;
        end
        return tab[qp - 16];
    endfunction

    // snake order, even columns down and odd columns up
    function automatic ime_mv_t expect_mv(input int n);
        ime_mv_t mv;
        int c;
        int p;
        c = n / `IME_ROW_POS;
        p = n % `IME_ROW_POS;
        mv.mv_x = MV_W'(c * `IME_PE_NUM - `IME_MV_OFS);
        mv.mv_y = MV_W'(((c % 2 == 0) ? p : `IME_ROW_POS - 1 - p) - `IME_MV_OFS);
        return mv;
    endfunction

    function automatic ref_blk_t expect_blk(input ime_mv_t mv);
        ref_blk_t blk;
        int r0;
        int c0;
        r0 = int'(mv.mv_y) + `IME_MV_OFS;
        c0 = int'(mv.mv_x) + `IME_MV_OFS;
        for (int k = 0; k < `IME_MB_W; k++) begin
            for (int j = 0; j < REF_W; j++) begin
                blk[k][j] = window_pix(r0 + k, c0 + j);
            end
        end
        return blk;
    endfunction

    // load rows, then per column 32 fetches and one step without fetch
    function automatic fetch_req_t expect_req(input int i);
        fetch_req_t req;
        int j;
        int c;
        int p;
        req = '0;
        if (i < `IME_MB_W) begin
            req.load = 1'b1;
            req.addr = ROW_W'(i);
            return req;
        end
        j = i - `IME_MB_W;
        c = j / `IME_ROW_POS;
        p = j % `IME_ROW_POS;
        if (p < `IME_ROW_POS - 1) begin
            req.load = 1'b1;
            req.addr = ROW_W'((c % 2 == 0) ? `IME_MB_W + p : `IME_ROW_POS - 2 - p);
        end
        return req;
    endfunction

    // fetch unit answers one cycle after the request
    initial begin
        fetch_data_i = '0;
        forever begin
            @(negedge clk);
            model_req = fetch_req_o;
            @(posedge clk);
            #1;
            fetch_data_i = model_req.load ? window_row(int'(model_req.addr)) : '0;
        end
    end

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_lambda(input string name, input lambda_t got, input lambda_t exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_mv(input string name, input ime_mv_t got, input ime_mv_t exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_req(input string name, input fetch_req_t got, input fetch_req_t exp);
        if (got.load !== exp.load || (exp.load && got.addr !== exp.addr)) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // one error per block, first wrong pixel shown
    task automatic compare_blk(input string name, input ref_blk_t got, input ref_blk_t exp);
        for (int k = 0; k < `IME_MB_W; k++) begin
            for (int j = 0; j < REF_W; j++) begin
                if (got[k][j] !== exp[k][j]) begin
                    $display("Error %s[%0d][%0d]: got 0x%h, expected 0x%h",
                             name, k, j, got[k][j], exp[k][j]);
                    errors++;
                    return;
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // frame helpers
    // ------------------------------------------------------------
    task automatic reset_dut(input int cycles);
        rstn = 1'b0;
        repeat (cycles) @(posedge clk);
        #1;
        rstn = 1'b1;
    endtask

    task automatic check_requests(input logic chk);
        int wait_cnt;
        if (!chk) begin
            return;
        end
        wait_cnt = 0;
        @(negedge clk);
        while (!fetch_req_o.load) begin
            if (wait_cnt == 20) begin
                $display("no fetch request within 20 cycles of the window becoming valid");
                errors++;
                return;
            end
            @(negedge clk);
            wait_cnt++;
        end
        for (int i = 0; i < REQ_CYCLES; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            compare_req("fetch_req_o", fetch_req_o, expect_req(i));
        end
        repeat (3) begin
            @(negedge clk);
            compare_req("fetch_req_o", fetch_req_o, '0);
        end
    endtask

    task automatic check_outputs(input qp_t qp, input logic chk_mv, input logic chk_blk);
        int      wait_cnt;
        ime_mv_t exp_mv;
        wait_cnt = 0;
        @(negedge clk);
        while (!sad_run_o) begin
            compare_bit("done_o", done_o, 1'b0);
            if (wait_cnt == 20) begin
                $display("no candidate within 20 cycles of the window becoming valid");
                errors++;
                return;
            end
            @(negedge clk);
            wait_cnt++;
        end
        for (int n = 0; n < SCAN_CANDS; n++) begin
            if (n > 0) begin
                @(negedge clk);
            end
            exp_mv = expect_mv(n);
            compare_bit("sad_run_o", sad_run_o, 1'b1);
            compare_bit("done_o", done_o, 1'b0);
            compare_bit("fetch_start_o", fetch_start_o, 1'b0);
            compare_lambda("sad_lambda_o", sad_lambda_o, expect_lambda(qp));
            if (chk_mv) begin
                compare_mv("sad_mv_o", sad_mv_o, exp_mv);
            end
            if (chk_blk) begin
                compare_blk("sad_ref_blk_o", sad_ref_blk_o, expect_blk(exp_mv));
            end
        end
        @(negedge clk);
        compare_bit("sad_run_o", sad_run_o, 1'b0);
        compare_bit("done_o", done_o, 1'b1);
        @(negedge clk);
        compare_bit("done_o", done_o, 1'b0);
        compare_bit("fetch_start_o", fetch_start_o, 1'b0);
    endtask

    // start with another qp in the middle of the scan
    task automatic inject_start(input qp_t qp);
        repeat (120) @(posedge clk);
        #1;
        start_i = 1'b1;
        qp_i    = qp ^ qp_t'(6'h2a);
        @(posedge clk);
        #1;
        start_i = 1'b0;
        qp_i    = qp;
    endtask

    // chk bit 0 motion vectors, bit 1 blocks, bit 2 fetch requests
    task automatic run_frame(input qp_t qp, input logic stray, input logic [2:0] chk);
        base = 8'($random(seed));
        @(posedge clk);
        #1;
        start_i = 1'b1;
        qp_i    = qp;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        @(negedge clk);
        compare_bit("fetch_start_o", fetch_start_o, 1'b1);
        repeat (3) @(posedge clk);
        #1;
        fetch_valid_i = 1'b1;
        fork
            check_requests(chk[2]);
            check_outputs(qp, chk[0], chk[1]);
            if (stray) inject_start(qp);
        join
        @(posedge clk);
        #1;
        fetch_valid_i = 1'b0;
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_reset();
        @(negedge clk);
        compare_bit("sad_run_o", sad_run_o, 1'b0);
        compare_bit("done_o", done_o, 1'b0);
        compare_bit("fetch_start_o", fetch_start_o, 1'b0);
        compare_req("fetch_req_o", fetch_req_o, '0);
        compare_lambda("sad_lambda_o", sad_lambda_o, '0);
    endtask

    // window never becomes valid here, reset brings the FSM back to idle
    task automatic test_lambda();
        qp_t qps [7];
        qps = '{0, 15, 16, 26, 39, 51, 63};
        for (int i = 0; i < 7; i++) begin
            @(posedge clk);
            #1;
            start_i = 1'b1;
            qp_i    = qps[i];
            @(posedge clk);
            #1;
            start_i = 1'b0;
            @(negedge clk);
            compare_lambda("sad_lambda_o", sad_lambda_o, expect_lambda(qps[i]));
            @(posedge clk);
            #1;
            reset_dut(2);
        end
    endtask

    task automatic test_scan_order();
        run_frame(qp_t'(20), 1'b0, 3'b001);
    endtask

    task automatic test_ref_block();
        run_frame(qp_t'(28), 1'b0, 3'b010);
    endtask

    task automatic test_fetch_requests();
        run_frame(qp_t'(30), 1'b1, 3'b100);
    endtask

    task automatic test_back_to_back();
        run_frame(qp_t'(22), 1'b0, 3'b111);
        run_frame(qp_t'(45), 1'b0, 3'b111);
    endtask

    initial begin
        errors        = 0;
        seed          = 12;
        base          = '0;
        rstn          = 1'b0;
        start_i       = 1'b0;
        qp_i          = '0;
        fetch_valid_i = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_reset();
        test_lambda();
        test_scan_order();
        test_ref_block();
        test_fetch_requests();
        test_back_to_back();
        $display("tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== ime_top.f ====
+incdir+common
common/ime_pkg.sv
ref_array/ref_row_array.sv
hw/lambda_lut.sv
hw/mv_align.sv
hw/ime_scan_ctrl.sv
hw/ime_top.sv
dv/tb_ime_top.sv

// ==== Bender.yml ====
package:
  name: ime_top

export_include_dirs:
  - common

sources:
  - common/ime_pkg.sv
  - ref_array/ref_row_array.sv
  - hw/lambda_lut.sv
  - hw/mv_align.sv
  - hw/ime_scan_ctrl.sv
  - hw/ime_top.sv
  - target: test
    files:
      - dv/tb_ime_top.sv
